//--- design/alu_unit.sv
`timescale 1ns/1ps
`include "tomasulo_settings.svh"
`default_nettype none

module alu_unit (
  input  wire                          clk_in,
  input  wire                          rst_in,
  input  wire                          dispatch_valid,
  input  wire tomasulo_pkg::dispatch_t dispatch_in,
  input  wire                          grant,
  output logic                         alu_busy,
  output logic                         result_req,
  output tomasulo_pkg::fu_result_t     result_out
);
  import tomasulo_pkg::*;

  dispatch_t  op_q;    // instruction in flight
  logic       busy_q;
  logic       take;
  logic [4:0] shamt;
  logic       lt_flag;
  data_t      res;

  assign take = dispatch_valid && !busy_q;

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      busy_q <= 1'b0;
    end else if (take) begin
      busy_q <= 1'b1;
    end else if (grant) begin
      busy_q <= 1'b0;  // result leaves on the bus next edge
    end
  end

  always_ff @(posedge clk_in) begin
    if (take) begin
      op_q <= dispatch_in;
    end
  end

  assign shamt = op_q.val2[4:0];  // RV32 shift amount

  always_comb begin
    lt_flag = 1'b0;
    unique case (op_q.func)
      func_slt:  lt_flag = op_q.val1 < op_q.val2;  // signed compare
      func_sltu: lt_flag = $unsigned(op_q.val1) < $unsigned(op_q.val2);
      default:   lt_flag = 1'b0;
    endcase
  end

  always_comb begin
    unique case (op_q.func)
      func_add:  res = op_q.val1 + op_q.val2;
      func_sub:  res = op_q.val1 - op_q.val2;
      func_and:  res = op_q.val1 & op_q.val2;
      func_or:   res = op_q.val1 | op_q.val2;
      func_xor:  res = op_q.val1 ^ op_q.val2;
      func_slt,
      func_sltu: res = {{(`XLEN-1){1'b0}}, lt_flag};
      func_sll:  res = op_q.val1 << shamt;
      func_srl:  res = op_q.val1 >> shamt;   // zero fill
      func_sra:  res = op_q.val1 >>> shamt;  // sign fill
      default:   res = '0;
    endcase
  end

  assign alu_busy           = busy_q;
  assign result_req         = busy_q;  // held until granted
  assign result_out.rob_idx = op_q.rob_idx;
  assign result_out.value   = res;

endmodule

`default_nettype wire

//--- design/cdb_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module cdb_arbiter (
  input  wire                                 clk_in,
  input  wire                                 rst_in,
  input  wire [1:0]                           result_req,
  input  wire tomasulo_pkg::fu_result_t [1:0] result_in,
  output logic [1:0]                          grant,
  output tomasulo_pkg::cdb_t                  cdb_out
);
  import tomasulo_pkg::*;

  logic       last_q;   // index of the previous winner
  logic       valid_q;
  fu_result_t bus_q;    // broadcast payload
  fu_result_t winner;

  always_comb begin
    if (result_req == 2'b11) begin
      grant = last_q ? 2'b01 : 2'b10;  // the other side goes first
    end else begin
      grant = result_req;
    end
  end

  assign winner = grant[1] ? result_in[1] : result_in[0];

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      valid_q <= 1'b0;
      last_q  <= 1'b0;
    end else begin
      valid_q <= |grant;  // one bus cycle per result
      if (|grant) begin
        last_q <= grant[1];
      end
    end
  end

  always_ff @(posedge clk_in) begin
    if (|grant) begin
      bus_q <= winner;
    end
  end

  assign cdb_out.valid   = valid_q;
  assign cdb_out.rob_idx = bus_q.rob_idx;
  assign cdb_out.value   = bus_q.value;

endmodule

`default_nettype wire

//--- design/exec_cluster.sv
`timescale 1ns/1ps
`default_nettype none

module exec_cluster (
  input  wire                       clk_in,
  input  wire                       rst_in,
  input  wire                       issue_valid,
  input  wire tomasulo_pkg::issue_t issue_in,
  output logic [1:0]                station_free,
  output tomasulo_pkg::cdb_t        cdb_out
);
  import tomasulo_pkg::*;

  // index 0 is the arithmetic lane, index 1 the logic lane
  logic             is_logic;
  logic [1:0]       issue_strobe;
  logic [1:0]       alu_busy;
  logic [1:0]       dispatch_valid;
  logic [1:0]       result_req;
  logic [1:0]       grant;
  dispatch_t        dispatch [2];
  fu_result_t [1:0] result;

  always_comb begin
    unique case (issue_in.func)
      func_and, func_or, func_xor, func_sll, func_srl, func_sra: is_logic = 1'b1;
      default: is_logic = 1'b0;  // add sub slt sltu
    endcase
  end

  assign issue_strobe[0] = issue_valid && !is_logic;
  assign issue_strobe[1] = issue_valid && is_logic;

  reservation_station arith_rs_inst (
    .clk_in(clk_in),
    .rst_in(rst_in),
    .issue_strobe(issue_strobe[0]),
    .issue_in(issue_in),
    .cdb_in(cdb_out),
    .alu_busy(alu_busy[0]),
    .station_free(station_free[0]),
    .dispatch_valid(dispatch_valid[0]),
    .dispatch_out(dispatch[0])
  );

  reservation_station logic_rs_inst (
    .clk_in(clk_in),
    .rst_in(rst_in),
    .issue_strobe(issue_strobe[1]),
    .issue_in(issue_in),
    .cdb_in(cdb_out),
    .alu_busy(alu_busy[1]),
    .station_free(station_free[1]),
    .dispatch_valid(dispatch_valid[1]),
    .dispatch_out(dispatch[1])
  );

  alu_unit arith_alu_inst (
    .clk_in(clk_in),
    .rst_in(rst_in),
    .dispatch_valid(dispatch_valid[0]),
    .dispatch_in(dispatch[0]),
    .grant(grant[0]),
    .alu_busy(alu_busy[0]),
    .result_req(result_req[0]),
    .result_out(result[0])
  );

  alu_unit logic_alu_inst (
    .clk_in(clk_in),
    .rst_in(rst_in),
    .dispatch_valid(dispatch_valid[1]),
    .dispatch_in(dispatch[1]),
    .grant(grant[1]),
    .alu_busy(alu_busy[1]),
    .result_req(result_req[1]),
    .result_out(result[1])
  );

  cdb_arbiter cdb_arbiter_inst (
    .clk_in(clk_in),
    .rst_in(rst_in),
    .result_req(result_req),
    .result_in(result),
    .grant(grant),
    .cdb_out(cdb_out)
  );

endmodule

`default_nettype wire

//--- design/reservation_station.sv
`timescale 1ns/1ps
`include "tomasulo_settings.svh"
`default_nettype none

module reservation_station (
  input  wire                       clk_in,
  input  wire                       rst_in,
  input  wire                       issue_strobe,
  input  wire tomasulo_pkg::issue_t issue_in,
  input  wire tomasulo_pkg::cdb_t   cdb_in,
  input  wire                       alu_busy,
  output logic                      station_free,
  output logic                      dispatch_valid,
  output tomasulo_pkg::dispatch_t   dispatch_out
);
  import tomasulo_pkg::*;

  localparam int IDX_W = $clog2(`RS_DEPTH);

  logic [`RS_DEPTH-1:0] busy_row;   // row holds an instruction
  logic [`RS_DEPTH-1:0] ready_row;  // busy with both operands as values
  alu_func_t            func_row [`RS_DEPTH];
  rob_tag_t             rob_row  [`RS_DEPTH];
  operand_t             src1_row [`RS_DEPTH];
  operand_t             src2_row [`RS_DEPTH];

  logic [IDX_W-1:0] open_idx;  // lowest free row
  logic [IDX_W-1:0] pick_idx;  // lowest ready row
  logic             has_open;
  logic             has_pick;
  logic             do_issue;

  // a waiting operand takes the broadcast value when its producer tag matches
  function automatic operand_t snoop(operand_t op, cdb_t cdb);
    operand_t res;
    res = op;
    if (!op.ready && cdb.valid && op.word.tag_view.tag == cdb.rob_idx) begin
      res.ready      = 1'b1;
      res.word.value = cdb.value;
    end
    return res;
  endfunction

  always_comb begin
    open_idx = '0;
    has_open = 1'b0;
    for (int i = `RS_DEPTH - 1; i >= 0; i--) begin  // downward so the lowest wins
      if (!busy_row[i]) begin
        open_idx = IDX_W'(i);
        has_open = 1'b1;
      end
    end
  end

  always_comb begin
    for (int i = 0; i < `RS_DEPTH; i++) begin
      ready_row[i] = busy_row[i] && src1_row[i].ready && src2_row[i].ready;
    end
  end

  always_comb begin
    pick_idx = '0;
    has_pick = 1'b0;
    for (int i = `RS_DEPTH - 1; i >= 0; i--) begin
      if (ready_row[i]) begin
        pick_idx = IDX_W'(i);
        has_pick = 1'b1;
      end
    end
  end

  assign station_free   = has_open;
  assign do_issue       = issue_strobe && has_open;
  assign dispatch_valid = has_pick && !alu_busy;  // ALU latches at the next edge

  always_comb begin
    dispatch_out.func    = func_row[pick_idx];
    dispatch_out.val1    = src1_row[pick_idx].word.value;
    dispatch_out.val2    = src2_row[pick_idx].word.value;
    dispatch_out.rob_idx = rob_row[pick_idx];
  end

  // row occupancy
  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      busy_row <= '0;
    end else begin
      if (dispatch_valid) begin
        busy_row[pick_idx] <= 1'b0;  // freed as it leaves
      end
      if (do_issue) begin
        busy_row[open_idx] <= 1'b1;
      end
    end
  end

  // row contents with wakeup from the CDB
  always_ff @(posedge clk_in) begin
    for (int i = 0; i < `RS_DEPTH; i++) begin
      src1_row[i] <= snoop(src1_row[i], cdb_in);
      src2_row[i] <= snoop(src2_row[i], cdb_in);
    end
    if (do_issue) begin
      func_row[open_idx] <= issue_in.func;
      rob_row[open_idx]  <= issue_in.rob_idx;
      // a tag broadcast in the issue cycle is caught by the incoming entry
      src1_row[open_idx] <= snoop(issue_in.src1, cdb_in);
      src2_row[open_idx] <= snoop(issue_in.src2, cdb_in);
    end
  end

endmodule

`default_nettype wire

//--- design/tomasulo_pkg.sv
`include "tomasulo_settings.svh"
`default_nettype none

package tomasulo_pkg;

  typedef logic signed [`XLEN-1:0] data_t;
  typedef logic [`ROB_TAG_W-1:0] rob_tag_t;

  // add sub slt sltu form the arithmetic class and the rest form the logic class
  typedef enum logic [`FUNC_W-1:0] {
    func_add,
    func_sub,
    func_and,
    func_or,
    func_xor,
    func_slt,
    func_sltu,
    func_sll,
    func_srl,
    func_sra
  } alu_func_t;

  // one operand word read as a value once ready and as a producer tag before that
  typedef union packed {
    data_t value;
    struct packed {
      logic [`XLEN-`ROB_TAG_W-1:0] pad;  // unused while waiting
      rob_tag_t                    tag;
    } tag_view;
  } operand_u;

  typedef struct packed {
    logic     ready;  // set when the word holds a value rather than a tag
    operand_u word;
  } operand_t;

  typedef struct packed {
    alu_func_t func;
    operand_t  src1;
    operand_t  src2;
    rob_tag_t  rob_idx;  // destination entry
  } issue_t;

  typedef struct packed {
    alu_func_t func;
    data_t     val1;
    data_t     val2;
    rob_tag_t  rob_idx;
  } dispatch_t;

  typedef struct packed {
    logic     valid;
    rob_tag_t rob_idx;
    data_t    value;
  } cdb_t;

  typedef struct packed {
    rob_tag_t rob_idx;
    data_t    value;
  } fu_result_t;

endpackage

`default_nettype wire

//--- design/tomasulo_settings.svh
`ifndef TOMASULO_SETTINGS_SVH
`define TOMASULO_SETTINGS_SVH
`default_nettype none

`define XLEN      32  // data path width
`define ROB_TAG_W 3   // reorder buffer of 8 entries
`define RS_DEPTH  3   // rows in each reservation station
`define FUNC_W    4   // alu function code

`default_nettype wire
`endif

//--- exec_cluster.f
+incdir+design
design/tomasulo_pkg.sv
design/reservation_station.sv
design/alu_unit.sv
design/cdb_arbiter.sv
design/exec_cluster.sv
tests/exec_cluster_chk.sv
tests/exec_cluster_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build the exec_cluster testbench with Verilator and run it
set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
  --top-module exec_cluster_tb \
  -f exec_cluster.f \
  -o exec_cluster_sim
status=$?
if [ "$status" -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit "$status"
fi

./obj_dir/exec_cluster_sim
status=$?
if [ "$status" -ne 0 ]; then
  echo "simulation failed with status $status"
  exit "$status"
fi

exit 0

//--- tests/exec_cluster_chk.sv
`timescale 1ns/1ps
`default_nettype none

module exec_cluster_chk (
  input wire                     clk_in,
  input wire                     rst_in,
  input wire                     issue_valid,
  input wire                     is_logic,
  input wire [1:0]               station_free,
  input wire [1:0]               result_req,
  input wire [1:0]               grant,
  input wire tomasulo_pkg::cdb_t cdb_out
);

  grant_onehot: assert property (@(posedge clk_in) disable iff (rst_in) $onehot0(grant))
    else $error("CDB grant is not one-hot");

  // is_logic selects the free bit of the target station
  issue_when_free: assert property (@(posedge clk_in) disable iff (rst_in)
    issue_valid |-> station_free[is_logic])
    else $error("issue strobe while the target station is full");

  for (genvar i = 0; i < 2; i++) begin : req_lane
    req_held: assert property (@(posedge clk_in) disable iff (rst_in)
      result_req[i] && !grant[i] |=> result_req[i])
      else $error("ALU %0d dropped its request before the grant", i);
  end

  cdb_known: assert property (@(posedge clk_in) disable iff (rst_in)
    cdb_out.valid |-> !$isunknown(cdb_out))
    else $error("CDB payload unknown while valid is high");

endmodule

bind exec_cluster exec_cluster_chk exec_cluster_chk_inst (
  .clk_in(clk_in),
  .rst_in(rst_in),
  .issue_valid(issue_valid),
  .is_logic(is_logic),
  .station_free(station_free),
  .result_req(result_req),
  .grant(grant),
  .cdb_out(cdb_out)
);

`default_nettype wire

//--- tests/exec_cluster_tb.sv
`timescale 1ns/1ps
`default_nettype none

module exec_cluster_tb;
  import tomasulo_pkg::*;

  localparam int NUM_ISSUED  = 28;  // 10 + 2 + 4 + 12 instructions
  localparam int CYCLE_LIMIT = 40 * NUM_ISSUED + 200;

  logic       clk_in;
  logic       rst_in;
  logic       issue_valid;
  issue_t     issue_in;
  logic [1:0] station_free;
  cdb_t       cdb_out;

  integer seed = 65199;
  int     cycle_cnt;
  int     issued_cnt [8];  // per ROB index, bumped by the issue side
  int     seen_cnt   [8];  // per ROB index, bumped by the CDB monitor
  data_t  exp_value  [8];
  string  cur_test;

  exec_cluster exec_cluster_inst (
    .clk_in(clk_in),
    .rst_in(rst_in),
    .issue_valid(issue_valid),
    .issue_in(issue_in),
    .station_free(station_free),
    .cdb_out(cdb_out)
  );

  initial begin
    clk_in = 1'b0;
    forever #50 clk_in = ~clk_in;
  end

  // reference ALU built from the RV32 rules
  function automatic data_t alu_model(alu_func_t f, data_t a, data_t b);
    logic [4:0] sh;
    data_t      r;
    sh = b[4:0];
    r  = '0;
    case (f)
      func_add:  r = a + b;
      func_sub:  r = a - b;
      func_and:  r = a & b;
      func_or:   r = a | b;
      func_xor:  r = a ^ b;
      func_slt:  r[0] = a < b;  // both signed
      func_sltu: r[0] = $unsigned(a) < $unsigned(b);
      func_sll:  r = a << sh;
      func_srl:  r = data_t'($unsigned(a) >> sh);
      func_sra:  r = a >>> sh;
      default:   r = '0;
    endcase
    return r;
  endfunction

  function automatic logic is_logic_func(alu_func_t f);
    return f inside {func_and, func_or, func_xor, func_sll, func_srl, func_sra};
  endfunction

  function automatic operand_t val_op(data_t v);
    operand_t op;
    op.ready      = 1'b1;
    op.word.value = v;
    return op;
  endfunction

  function automatic operand_t tag_op(rob_tag_t t);
    operand_t op;
    op.ready             = 1'b0;
    op.word.tag_view.pad = '0;
    op.word.tag_view.tag = t;
    return op;
  endfunction

  // even slots arithmetic, odd slots logic
  function automatic alu_func_t contention_func(int i);
    alu_func_t f;
    if (i % 2 == 0) begin
      case ((i / 2) % 4)
        0:       f = func_add;
        1:       f = func_sub;
        2:       f = func_slt;
        default: f = func_sltu;
      endcase
    end else begin
      case ((i / 2) % 6)
        0:       f = func_and;
        1:       f = func_or;
        2:       f = func_xor;
        3:       f = func_sll;
        4:       f = func_srl;
        default: f = func_sra;
      endcase
    end
    return f;
  endfunction

  function automatic logic all_seen();
    for (int i = 0; i < 8; i++) begin
      if (seen_cnt[i] != issued_cnt[i]) begin
        return 1'b0;
      end
    end
    return 1'b1;
  endfunction

  task automatic check_cdb(input cdb_t expected, input cdb_t actual);
    logic bad;
    if (!expected.valid) begin
      bad = actual.valid !== 1'b0;  // idle bus, payload is don't care
    end else begin
      bad = actual !== expected;
    end
    if (bad) begin
      $display("ERROR %s: expected valid=%0b rob=%0d value=%h, actual valid=%0b rob=%0d value=%h",
               cur_test, expected.valid, expected.rob_idx, expected.value,
               actual.valid, actual.rob_idx, actual.value);
      $display("Test FAILED");
      $fatal(1, "CDB mismatch");
    end
  endtask

  task automatic check_free(input logic [1:0] expected, input logic [1:0] actual);
    if (actual !== expected) begin
      $display("ERROR %s: station_free expected %b, actual %b", cur_test, expected, actual);
      $display("Test FAILED");
      $fatal(1, "station_free mismatch");
    end
  endtask

  task automatic record_broadcast(input cdb_t got);
    cdb_t expected;
    expected.valid   = 1'b1;
    expected.rob_idx = got.rob_idx;
    expected.value   = exp_value[got.rob_idx];
    if (seen_cnt[got.rob_idx] >= issued_cnt[got.rob_idx]) begin
      $display("ROB index %0d was broadcast in %s without an instruction waiting for it",
               got.rob_idx, cur_test);
      $display("Test FAILED");
      $fatal(1, "unexpected or duplicate broadcast");
    end else begin
      check_cdb(expected, got);
      seen_cnt[got.rob_idx] = seen_cnt[got.rob_idx] + 1;
    end
  endtask

  // CDB monitor, samples well after the edge
  always begin
    @(posedge clk_in);
    #10;
    if (!rst_in && cdb_out.valid) begin
      record_broadcast(cdb_out);
    end
  end

  always @(posedge clk_in) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= CYCLE_LIMIT) begin
      for (int i = 0; i < 8; i++) begin
        if (seen_cnt[i] != issued_cnt[i]) begin
          $display("no broadcast arrived for ROB index %0d", i);
        end
      end
      $display("timeout: %s still running after %0d cycles", cur_test, CYCLE_LIMIT);
      $display("Test FAILED");
      $fatal(1, "timeout");
    end
  end

  // waits for a free row and a retired ROB index, then strobes for one cycle
  task automatic issue_op(alu_func_t f, operand_t s1, operand_t s2, rob_tag_t idx,
                          data_t expv);
    int lane;
    lane = is_logic_func(f) ? 1 : 0;
    while (!station_free[lane] || issued_cnt[idx] != seen_cnt[idx]) begin
      @(negedge clk_in);
    end
    exp_value[idx]   = expv;
    issued_cnt[idx]  = issued_cnt[idx] + 1;
    issue_in.func    = f;
    issue_in.src1    = s1;
    issue_in.src2    = s2;
    issue_in.rob_idx = idx;
    issue_valid      = 1'b1;
    @(negedge clk_in);
    issue_valid = 1'b0;
  endtask

  task automatic wait_drain();
    while (!all_seen()) begin
      @(negedge clk_in);
    end
  endtask

  task automatic test_reset();
    cdb_t idle;
    cur_test   = "test_reset";
    idle       = '0;
    check_free(2'b11, station_free);
    check_cdb(idle, cdb_out);
  endtask

  task automatic test_functions();
    alu_func_t f;
    data_t     a;
    data_t     b;
    cur_test = "test_functions";
    for (int i = 0; i < 10; i++) begin
      f = alu_func_t'(i);
      a = $random(seed);
      b = $random(seed);
      issue_op(f, val_op(a), val_op(b), rob_tag_t'(i % 8), alu_model(f, a, b));
    end
    wait_drain();
  endtask

  task automatic test_dependency();
    data_t a;
    data_t b;
    data_t c;
    data_t p;
    cur_test = "test_dependency";
    a = $random(seed);
    b = $random(seed);
    c = $random(seed);
    p = alu_model(func_sub, a, b);
    issue_op(func_sub, val_op(a), val_op(b), 3'd3, p);
    issue_op(func_xor, tag_op(3'd3), val_op(c), 3'd4, alu_model(func_xor, p, c));
    wait_drain();
  endtask

  task automatic test_full_station();
    data_t p;
    data_t q;
    data_t t;
    data_t v [3];
    cur_test = "test_full_station";
    p = $random(seed);
    q = $random(seed);
    for (int i = 0; i < 3; i++) begin
      v[i] = $random(seed);
    end
    t = alu_model(func_or, p, q);  // producer of tag 7
    issue_op(func_add, tag_op(3'd7), val_op(v[0]), 3'd0, alu_model(func_add, t, v[0]));
    issue_op(func_sub, tag_op(3'd7), val_op(v[1]), 3'd1, alu_model(func_sub, t, v[1]));
    issue_op(func_sltu, val_op(v[2]), tag_op(3'd7), 3'd2, alu_model(func_sltu, v[2], t));
    check_free(2'b10, station_free);
    issue_op(func_or, val_op(p), val_op(q), 3'd7, t);
    wait_drain();
    check_free(2'b11, station_free);
  endtask

  task automatic test_contention();
    alu_func_t f;
    data_t     a;
    data_t     b;
    cur_test = "test_contention";
    for (int i = 0; i < 12; i++) begin
      f = contention_func(i);
      a = $random(seed);
      b = $random(seed);
      issue_op(f, val_op(a), val_op(b), rob_tag_t'(i % 8), alu_model(f, a, b));
    end
    wait_drain();
  endtask

  initial begin
    rst_in      = 1'b1;
    issue_valid = 1'b0;
    issue_in    = '0;
    cur_test    = "reset";
    repeat (4) @(posedge clk_in);
    @(negedge clk_in);
    rst_in = 1'b0;
    test_reset();
    test_functions();
    test_dependency();
    test_full_station();
    test_contention();
    $display("Test OK");
    $finish;
  end

endmodule

`default_nettype wire
